// File: harness_params.svh
// --------------------------------------------------------------------------
// Harness parameters for bus widths, bank geometry, the address map
// and the debug request hold-off
// --------------------------------------------------------------------------
`ifndef HARNESS_PARAMS_SVH
`define HARNESS_PARAMS_SVH

// Bus widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 64

// Banked memory, word interleaved
`define NUM_BANKS  4
`define BANK_WORDS 256

// Address map
`define MEM_BASE  32'h8000_0000
`define EXIT_ADDR 32'h0000_1000

// Cycles after power-on reset before debug requests pass
`define DM_DELAY_CYCLES 500

`endif

// File: harness_bus_pkg.sv
// --------------------------------------------------------------------------
// Bus types of the memory harness, with request and response structs
// --------------------------------------------------------------------------
`include "harness_params.svh"

package harness_bus_pkg;

  typedef logic [`ADDR_WIDTH-1:0]         addr_t;
  typedef logic [`DATA_WIDTH-1:0]         data_t;
  typedef logic [`DATA_WIDTH/8-1:0]       strb_t;
  typedef logic [$clog2(`BANK_WORDS)-1:0] word_idx_t;
  typedef logic [$clog2(`NUM_BANKS)-1:0]  bank_idx_t;

  // Single-cycle request strobe, never stalled
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    strb_t be;
    data_t wdata;
  } mem_req_t;

  // Response, valid one cycle after the request
  typedef struct packed {
    logic  valid;
    logic  err;
    data_t rdata;
  } mem_rsp_t;

endpackage

// File: harness_ctrl_pkg.sv
// --------------------------------------------------------------------------
// Control types of the harness: exit code and debug gate
// --------------------------------------------------------------------------
`include "harness_params.svh"

package harness_ctrl_pkg;

  typedef logic [31:0] exit_code_t;

  // Holds the full hold-off count
  typedef logic [$clog2(`DM_DELAY_CYCLES+1)-1:0] dbg_cnt_t;

  typedef enum logic {
    DBG_HOLD = 1'b0,
    DBG_OPEN = 1'b1
  } dbg_state_e;

endpackage

// File: harness_rstgen.sv
// --------------------------------------------------------------------------
// Bus side reset, from power-on reset and debug module reset request
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module harness_rstgen (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic sys_rst_no
);

  logic       clr_n;
  logic [1:0] sync_q;

  // Either source clears at once
  assign clr_n = rst_ni & ~ndmreset_i;

  // Release walks through two flops
  always_ff @(posedge clk_i or negedge clr_n) begin : p_sync
    if (!clr_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[1];

endmodule

// File: harness_bus_decode.sv
// --------------------------------------------------------------------------
// Address decoder: bank strobes, unmapped detection, exit-code register
// and the response tag for the following cycle
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "harness_params.svh"

module harness_bus_decode (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  harness_bus_pkg::mem_req_t    req_i,
  output logic [`NUM_BANKS-1:0]        bank_req_o,
  output logic                         bank_we_o,
  output harness_bus_pkg::strb_t       bank_be_o,
  output harness_bus_pkg::data_t       bank_wdata_o,
  output harness_bus_pkg::word_idx_t   bank_word_o,
  output logic                         tag_valid_o,
  output harness_bus_pkg::bank_idx_t   tag_bank_o,
  output logic                         tag_mem_o,
  output logic                         tag_err_o,
  output harness_ctrl_pkg::exit_code_t tag_exit_o,
  output harness_ctrl_pkg::exit_code_t exit_o
);

  import harness_bus_pkg::*;
  import harness_ctrl_pkg::*;

  localparam int unsigned ByteBits = $clog2(`DATA_WIDTH / 8);
  localparam int unsigned BankBits = $bits(bank_idx_t);
  localparam int unsigned WordBits = $bits(word_idx_t);
  localparam addr_t       MemEnd   = `MEM_BASE + `NUM_BANKS * `BANK_WORDS * (`DATA_WIDTH / 8);

  typedef struct packed {
    logic       valid;
    bank_idx_t  bank;
    logic       mem;
    logic       err;
    exit_code_t exit_val;
  } tag_t;

  addr_t      mem_ofs;
  addr_t      word_addr;
  bank_idx_t  bank_sel;
  logic       in_mem;
  logic       is_exit;
  logic       req_ok;
  exit_code_t exit_q;
  tag_t       tag_d;
  tag_t       tag_q;

  // --------------------------------------------------------------------------
  // Address map
  // --------------------------------------------------------------------------
  assign in_mem    = (req_i.addr >= `MEM_BASE) && (req_i.addr < MemEnd);
  assign is_exit   = (req_i.addr == `EXIT_ADDR);
  assign mem_ofs   = req_i.addr - `MEM_BASE;
  assign word_addr = mem_ofs >> ByteBits;
  // Consecutive words rotate over the banks
  assign bank_sel  = word_addr[BankBits-1:0];

  // No bank access while the bus side is held in reset
  assign req_ok = req_i.req & rst_ni;

  always_comb begin : p_strobe
    bank_req_o           = '0;
    bank_req_o[bank_sel] = req_ok & in_mem;
  end

  assign bank_we_o    = req_i.we;
  assign bank_be_o    = req_i.be;
  assign bank_wdata_o = req_i.wdata;
  assign bank_word_o  = word_addr[BankBits +: WordBits];

  // --------------------------------------------------------------------------
  // Exit register and response tag
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_exit
    if (!rst_ni) begin
      exit_q <= '0;
    end else if (req_i.req && req_i.we && is_exit) begin
      exit_q <= req_i.wdata[$bits(exit_code_t)-1:0];
    end
  end

  always_comb begin : p_tag_d
    tag_d.valid    = req_i.req;
    tag_d.bank     = bank_sel;
    tag_d.mem      = req_i.req & in_mem;
    tag_d.err      = req_i.req & ~in_mem & ~is_exit;
    // Exit value only goes back on a read
    tag_d.exit_val = (req_i.req && !req_i.we && is_exit) ? exit_q : '0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_tag
    if (!rst_ni) begin
      tag_q <= '0;
    end else begin
      tag_q <= tag_d;
    end
  end

  assign tag_valid_o = tag_q.valid;
  assign tag_bank_o  = tag_q.bank;
  assign tag_mem_o   = tag_q.mem;
  assign tag_err_o   = tag_q.err;
  assign tag_exit_o  = tag_q.exit_val;
  assign exit_o      = exit_q;

  a_one_bank: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot0(bank_req_o)
  ) else $error("more than one bank strobe high");

endmodule

// File: harness_sram_bank.sv
// --------------------------------------------------------------------------
// One SRAM bank, word addressed, byte-masked write, registered read
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "harness_params.svh"

module harness_sram_bank (
  input  logic                       clk_i,
  input  logic                       req_i,
  input  logic                       we_i,
  input  harness_bus_pkg::strb_t     be_i,
  input  harness_bus_pkg::data_t     wdata_i,
  input  harness_bus_pkg::word_idx_t word_i,
  output harness_bus_pkg::data_t     rdata_o
);

  import harness_bus_pkg::*;

  data_t mem_q [`BANK_WORDS];
  data_t rdata_q;

  always_ff @(posedge clk_i) begin : p_write
    if (req_i && we_i) begin
      for (int unsigned b = 0; b < $bits(strb_t); b++) begin
        if (be_i[b]) begin
          mem_q[word_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Read data holds until the next read
  always_ff @(posedge clk_i) begin : p_read
    if (req_i && !we_i) begin
      rdata_q <= mem_q[word_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: harness_rsp_mux.sv
// --------------------------------------------------------------------------
// Response mux: picks bank data, exit value or zero from the tag
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "harness_params.svh"

module harness_rsp_mux (
  input  logic                                   tag_valid_i,
  input  harness_bus_pkg::bank_idx_t             tag_bank_i,
  input  logic                                   tag_mem_i,
  input  logic                                   tag_err_i,
  input  harness_ctrl_pkg::exit_code_t           tag_exit_i,
  input  harness_bus_pkg::data_t [`NUM_BANKS-1:0] bank_rdata_i,
  output harness_bus_pkg::mem_rsp_t              rsp_o
);

  import harness_bus_pkg::*;

  data_t rdata;

  always_comb begin : p_sel
    if (tag_mem_i) begin
      rdata = bank_rdata_i[tag_bank_i];
    end else if (tag_err_i) begin
      rdata = '0;
    end else begin
      // Exit read, or zero for an exit write
      rdata = data_t'(tag_exit_i);
    end
  end

  assign rsp_o = '{valid: tag_valid_i, err: tag_err_i, rdata: rdata};

  // Decoder never tags an access as both memory and unmapped
  always_comb begin : p_chk
    if (tag_valid_i) begin
      a_err_mem: assert final (!(tag_err_i && tag_mem_i))
        else $error("response tagged as memory and error");
    end
  end

endmodule

// File: harness_debug_gate.sv
// --------------------------------------------------------------------------
// Debug request gate: hold-off after power-on reset, then enable gating
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "harness_params.svh"

module harness_debug_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_enable_i,
  input  logic debug_req_i,
  output logic debug_req_o
);

  import harness_ctrl_pkg::*;

  dbg_state_e state_d;
  dbg_state_e state_q;
  dbg_cnt_t   cnt_d;
  dbg_cnt_t   cnt_q;

  always_comb begin : p_next
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      DBG_HOLD: begin
        cnt_d = cnt_q - 1'b1;
        // Last hold cycle
        if (cnt_q == dbg_cnt_t'(1)) begin
          state_d = DBG_OPEN;
        end
      end
      DBG_OPEN: begin
        cnt_d = '0;
      end
      default: begin
        state_d = DBG_HOLD;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      state_q <= DBG_HOLD;
      cnt_q   <= dbg_cnt_t'(`DM_DELAY_CYCLES);
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  assign debug_req_o = (state_q == DBG_OPEN) & debug_enable_i & debug_req_i;

  a_hold_quiet: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (state_q == DBG_HOLD) |-> !debug_req_o
  ) else $error("debug request passed during hold-off");

endmodule

// File: harness_top.sv
// --------------------------------------------------------------------------
// Memory harness top: reset, decoder, SRAM banks, response mux, debug gate
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "harness_params.svh"

module harness_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         ndmreset_i,
  input  logic                         debug_enable_i,
  input  logic                         debug_req_i,
  input  harness_bus_pkg::mem_req_t    req_i,
  output harness_bus_pkg::mem_rsp_t    rsp_o,
  output harness_ctrl_pkg::exit_code_t exit_o,
  output logic                         sys_rst_no,
  output logic                         debug_req_o
);

  import harness_bus_pkg::*;
  import harness_ctrl_pkg::*;

  logic [`NUM_BANKS-1:0]  bank_req;
  logic                   bank_we;
  strb_t                  bank_be;
  data_t                  bank_wdata;
  word_idx_t              bank_word;
  data_t [`NUM_BANKS-1:0] bank_rdata;

  logic       tag_valid;
  bank_idx_t  tag_bank;
  logic       tag_mem;
  logic       tag_err;
  exit_code_t tag_exit;

  harness_rstgen i_rstgen (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ndmreset_i ( ndmreset_i ),
    .sys_rst_no ( sys_rst_no )
  );

  // --------------------------------------------------------------------------
  // Bus side
  // --------------------------------------------------------------------------
  harness_bus_decode i_decode (
    .clk_i        ( clk_i      ),
    .rst_ni       ( sys_rst_no ),
    .req_i        ( req_i      ),
    .bank_req_o   ( bank_req   ),
    .bank_we_o    ( bank_we    ),
    .bank_be_o    ( bank_be    ),
    .bank_wdata_o ( bank_wdata ),
    .bank_word_o  ( bank_word  ),
    .tag_valid_o  ( tag_valid  ),
    .tag_bank_o   ( tag_bank   ),
    .tag_mem_o    ( tag_mem    ),
    .tag_err_o    ( tag_err    ),
    .tag_exit_o   ( tag_exit   ),
    .exit_o       ( exit_o     )
  );

  for (genvar i = 0; i < `NUM_BANKS; i++) begin : gen_bank
    harness_sram_bank i_bank (
      .clk_i   ( clk_i         ),
      .req_i   ( bank_req[i]   ),
      .we_i    ( bank_we       ),
      .be_i    ( bank_be       ),
      .wdata_i ( bank_wdata    ),
      .word_i  ( bank_word     ),
      .rdata_o ( bank_rdata[i] )
    );
  end

  harness_rsp_mux i_rsp_mux (
    .tag_valid_i  ( tag_valid  ),
    .tag_bank_i   ( tag_bank   ),
    .tag_mem_i    ( tag_mem    ),
    .tag_err_i    ( tag_err    ),
    .tag_exit_i   ( tag_exit   ),
    .bank_rdata_i ( bank_rdata ),
    .rsp_o        ( rsp_o      )
  );

  // Debug gate sees power-on reset only
  harness_debug_gate i_debug_gate (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_i    ( debug_req_i    ),
    .debug_req_o    ( debug_req_o    )
  );

endmodule

// File: tb_harness_checks.sv
// --------------------------------------------------------------------------
// Concurrent checks of the harness ports against the testbench model
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "harness_params.svh"

module tb_harness_checks (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         ndmreset_i,
  input  logic                         sys_rst_ni,
  input  harness_bus_pkg::mem_rsp_t    rsp_i,
  input  harness_ctrl_pkg::exit_code_t exit_i,
  input  logic                         debug_req_i,
  input  harness_bus_pkg::mem_rsp_t    exp_rsp_i,
  input  logic                         exp_rdata_chk_i,
  input  harness_ctrl_pkg::exit_code_t exp_exit_i,
  input  logic                         exp_debug_i,
  output int unsigned                  value_errs_o,
  output int unsigned                  proto_errs_o
);

  int unsigned value_errs = 0;
  int unsigned proto_errs = 0;
  logic        src_ok;

  // Both reset sources inactive
  assign src_ok = rst_ni & ~ndmreset_i;

  // --------------------------------------------------------------------------
  // Bus responses
  // --------------------------------------------------------------------------
  a_rsp_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) rsp_i.valid === exp_rsp_i.valid
  ) else begin
    proto_errs++;
    if ($sampled(rsp_i.valid)) begin
      $display("response valid without a request one cycle earlier at %0t", $time);
    end else begin
      $display("request got no response in the following cycle at %0t", $time);
    end
  end

  a_rsp_err: assert property (
    @(posedge clk_i) disable iff (!rst_ni) exp_rsp_i.valid |-> rsp_i.err === exp_rsp_i.err
  ) else begin
    value_errs++;
    $display("[FAIL] rsp_o.err exp %h got %h", $sampled(exp_rsp_i.err), $sampled(rsp_i.err));
  end

  a_rsp_rdata: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (exp_rsp_i.valid && exp_rdata_chk_i) |-> rsp_i.rdata === exp_rsp_i.rdata
  ) else begin
    value_errs++;
    $display("[FAIL] rsp_o.rdata exp %h got %h",
             $sampled(exp_rsp_i.rdata), $sampled(rsp_i.rdata));
  end

  // --------------------------------------------------------------------------
  // Exit code, debug request, bus reset
  // --------------------------------------------------------------------------
  a_exit: assert property (@(posedge clk_i) disable iff (!rst_ni) exit_i === exp_exit_i)
  else begin
    value_errs++;
    $display("[FAIL] exit_o exp %h got %h", $sampled(exp_exit_i), $sampled(exit_i));
  end

  a_debug: assert property (@(posedge clk_i) disable iff (!rst_ni) debug_req_i === exp_debug_i)
  else begin
    value_errs++;
    $display("[FAIL] debug_req_o exp %h got %h", $sampled(exp_debug_i), $sampled(debug_req_i));
  end

  // Released two edges after both sources go inactive
  a_bus_reset: assert property (
    @(posedge clk_i) sys_rst_ni === (src_ok && $past(src_ok) && $past(src_ok, 2))
  ) else begin
    value_errs++;
    $display("[FAIL] sys_rst_no exp %h got %h",
             !$sampled(sys_rst_ni), $sampled(sys_rst_ni));
  end

  assign value_errs_o = value_errs;
  assign proto_errs_o = proto_errs;

endmodule

// File: tb_harness.sv
// --------------------------------------------------------------------------
// Testbench of the memory harness: stimulus, reference model, report
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`include "harness_params.svh"

module tb_harness;

  import harness_bus_pkg::*;
  import harness_ctrl_pkg::*;

  localparam int unsigned MemWords = `NUM_BANKS * `BANK_WORDS;
  localparam addr_t       MemEnd   = `MEM_BASE + MemWords * 8;
  localparam addr_t       Unmapped [5] = '{32'h0000_0000, `EXIT_ADDR + 8, `MEM_BASE - 8,
                                           MemEnd, 32'hffff_fff8};

  logic        clk;
  logic        rst_n;
  logic        ndmreset;
  logic        dbg_enable;
  logic        dbg_req_in;
  logic        dbg_req_out;
  logic        sys_rst_n;
  mem_req_t    req;
  mem_rsp_t    rsp;
  exit_code_t  exit_code;

  // Reference model
  data_t       ref_mem [MemWords];
  mem_rsp_t    exp_rsp;
  logic        exp_rdata_chk;
  exit_code_t  exp_exit;
  int unsigned dbg_cycles;
  addr_t       addr_q [$];
  int unsigned value_errs;
  int unsigned proto_errs;
  int unsigned timeout_errs;

  initial begin : p_clk
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  harness_top DUT (
    .clk_i          ( clk         ),
    .rst_ni         ( rst_n       ),
    .ndmreset_i     ( ndmreset    ),
    .debug_enable_i ( dbg_enable  ),
    .debug_req_i    ( dbg_req_in  ),
    .req_i          ( req         ),
    .rsp_o          ( rsp         ),
    .exit_o         ( exit_code   ),
    .sys_rst_no     ( sys_rst_n   ),
    .debug_req_o    ( dbg_req_out )
  );

  tb_harness_checks i_checks (
    .clk_i           ( clk           ),
    .rst_ni          ( rst_n         ),
    .ndmreset_i      ( ndmreset      ),
    .sys_rst_ni      ( sys_rst_n     ),
    .rsp_i           ( rsp           ),
    .exit_i          ( exit_code     ),
    .debug_req_i     ( dbg_req_out   ),
    .exp_rsp_i       ( exp_rsp       ),
    .exp_rdata_chk_i ( exp_rdata_chk ),
    .exp_exit_i      ( exp_exit      ),
    .exp_debug_i     ( (dbg_cycles == `DM_DELAY_CYCLES) && dbg_enable && dbg_req_in ),
    .value_errs_o    ( value_errs    ),
    .proto_errs_o    ( proto_errs    )
  );

  // --------------------------------------------------------------------------
  // Model of the address map, memory and exit register
  // --------------------------------------------------------------------------
  always @(posedge clk or negedge sys_rst_n) begin : p_model
    int unsigned w;
    if (!sys_rst_n) begin
      exp_rsp       <= '0;
      exp_rdata_chk <= 1'b0;
      exp_exit      <= '0;
    end else begin
      exp_rsp       <= '0;
      exp_rdata_chk <= 1'b0;
      if (req.req) begin
        exp_rsp.valid <= 1'b1;
        if (req.addr >= `MEM_BASE && req.addr < MemEnd) begin
          w = (req.addr - `MEM_BASE) / 8;
          if (req.we) begin
            for (int b = 0; b < 8; b++) begin
              if (req.be[b]) begin
                ref_mem[w][b*8 +: 8] = req.wdata[b*8 +: 8];
              end
            end
          end else begin
            exp_rsp.rdata <= ref_mem[w];
            exp_rdata_chk <= 1'b1;
          end
        end else if (req.addr == `EXIT_ADDR) begin
          if (req.we) begin
            exp_exit <= req.wdata[31:0];
          end else begin
            exp_rsp.rdata <= {32'h0, exp_exit};
            exp_rdata_chk <= 1'b1;
          end
        end else begin
          exp_rsp.err   <= 1'b1;
          exp_rdata_chk <= 1'b1;
        end
      end
    end
  end

  // Hold-off counter of the debug gate, power-on reset only
  always @(posedge clk or negedge rst_n) begin : p_dbg_model
    if (!rst_n) begin
      dbg_cycles <= 0;
    end else if (dbg_cycles < `DM_DELAY_CYCLES) begin
      dbg_cycles <= dbg_cycles + 1;
    end
  end

  function automatic addr_t word_addr(input int unsigned w);
    return `MEM_BASE + addr_t'(w) * 8;
  endfunction

  function automatic data_t rand_data();
    return {$urandom(), $urandom()};
  endfunction

  task automatic send(input logic we, input addr_t addr, input strb_t be, input data_t wdata);
    @(posedge clk);
    req <= '{req: 1'b1, we: we, addr: addr, be: be, wdata: wdata};
  endtask

  task automatic go_idle();
    @(posedge clk);
    req <= '0;
  endtask

  task automatic wait_until(input logic for_debug, input int unsigned limit, input string what);
    int unsigned n;
    n = 0;
    while (!(for_debug ? dbg_req_out : sys_rst_n) && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (!(for_debug ? dbg_req_out : sys_rst_n)) begin
      timeout_errs++;
      $display("timed out after %0d cycles waiting for %s", limit, what);
    end
  endtask

  initial begin : p_stim
    int unsigned base;
    int unsigned w;
    void'($urandom(32'h28d8_da9e));
    timeout_errs = 0;
    rst_n        = 1'b0;
    ndmreset     = 1'b0;
    dbg_enable   = 1'b1;
    dbg_req_in   = 1'b1;
    req          = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    wait_until(1'b0, 20, "bus reset release");
    wait_until(1'b1, `DM_DELAY_CYCLES + 20, "debug request after hold-off");
    dbg_enable <= 1'b0;
    repeat (4) @(posedge clk);
    dbg_enable <= 1'b1;

    // Stream over every word, all banks in turn
    for (w = 0; w < MemWords; w++) begin
      send(1'b1, word_addr(w), '1, {~word_addr(w), word_addr(w)});
    end
    repeat (16) begin
      w = $urandom_range(MemWords - 1);
      addr_q.push_back(word_addr(w));
      send(1'b1, word_addr(w), strb_t'($urandom), rand_data());
    end
    foreach (addr_q[i]) begin
      send(1'b0, addr_q[i], '0, '0);
    end
    base = $urandom_range(MemWords - 64);
    for (w = base; w < base + 64; w++) begin
      send(($urandom & 1) != 0, word_addr(w), strb_t'($urandom), rand_data());
    end

    // Exit register, then unmapped accesses
    send(1'b1, `EXIT_ADDR, '1, rand_data());
    send(1'b0, `EXIT_ADDR, '0, '0);
    foreach (Unmapped[i]) begin
      send(1'b1, Unmapped[i], '1, rand_data());
      send(1'b0, Unmapped[i], '0, '0);
    end
    // Whole memory reads back after the unmapped writes
    for (w = 0; w < MemWords; w++) begin
      send(1'b0, word_addr(w), '0, '0);
    end
    send(1'b0, `EXIT_ADDR, '0, '0);
    go_idle();

    // Write during a debug module reset is dropped
    @(posedge clk);
    ndmreset <= 1'b1;
    send(1'b1, addr_q[0], '1, rand_data());
    go_idle();
    @(posedge clk);
    ndmreset <= 1'b0;
    wait_until(1'b0, 20, "bus reset release after ndmreset");
    foreach (addr_q[i]) begin
      send(1'b0, addr_q[i], '0, '0);
    end
    go_idle();
    repeat (3) @(posedge clk);

    $display("Error counts: %0d value, %0d protocol, %0d timeout",
             value_errs, proto_errs, timeout_errs);
    if (value_errs + proto_errs + timeout_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+.
harness_bus_pkg.sv
harness_ctrl_pkg.sv
harness_rstgen.sv
harness_bus_decode.sv
harness_sram_bank.sv
harness_rsp_mux.sv
harness_debug_gate.sv
harness_top.sv
tb_harness_checks.sv
tb_harness.sv

// File: Bender.yml
package:
  name: harness_mem

sources:
  - include_dirs:
      - .
    files:
      - harness_bus_pkg.sv
      - harness_ctrl_pkg.sv
      - harness_rstgen.sv
      - harness_bus_decode.sv
      - harness_sram_bank.sv
      - harness_rsp_mux.sv
      - harness_debug_gate.sv
      - harness_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_harness_checks.sv
      - tb_harness.sv
